//--- design/mesh_coord_pkg.sv
/* mesh coordinate package
   direction indices and coordinate widths shared by the pod mesh nodes */
package mesh_coord_pkg;

  localparam int num_dirs_c  = 7;
  localparam int dir_width_c = 3;

  // port order inside a node, P first
  localparam logic [dir_width_c-1:0] dir_p_c  = 3'd0;
  localparam logic [dir_width_c-1:0] dir_w_c  = 3'd1;
  localparam logic [dir_width_c-1:0] dir_e_c  = 3'd2;
  localparam logic [dir_width_c-1:0] dir_n_c  = 3'd3;
  localparam logic [dir_width_c-1:0] dir_s_c  = 3'd4;
  localparam logic [dir_width_c-1:0] dir_rw_c = 3'd5;
  localparam logic [dir_width_c-1:0] dir_re_c = 3'd6;

  // pod geometry
  localparam int x_cord_width_c = 4;  // tile columns plus the side columns
  localparam int y_cord_width_c = 3;

endpackage

//--- design/mesh_packet_pkg.sv
/* mesh packet package
   field widths and bit offsets of mesh link words and ruche link words */
package mesh_packet_pkg;

  localparam int payload_width_c   = 16;
  localparam int mesh_pkt_width_c  = 2 * mesh_coord_pkg::x_cord_width_c
                                   + 2 * mesh_coord_pkg::y_cord_width_c + payload_width_c;
  localparam int ruche_pkt_width_c = mesh_pkt_width_c - mesh_coord_pkg::y_cord_width_c;

  // mesh word, top down: dest_x, dest_y, src_x, src_y, payload
  localparam int mesh_payload_lsb_c = 0;
  localparam int mesh_src_y_lsb_c   = payload_width_c;
  localparam int mesh_src_x_lsb_c   = mesh_src_y_lsb_c + mesh_coord_pkg::y_cord_width_c;
  localparam int mesh_dest_y_lsb_c  = mesh_src_x_lsb_c + mesh_coord_pkg::x_cord_width_c;
  localparam int mesh_dest_x_lsb_c  = mesh_dest_y_lsb_c + mesh_coord_pkg::y_cord_width_c;

  // ruche word has no src_y
  localparam int ruche_payload_lsb_c = 0;
  localparam int ruche_src_x_lsb_c   = payload_width_c;
  localparam int ruche_dest_y_lsb_c  = ruche_src_x_lsb_c + mesh_coord_pkg::x_cord_width_c;
  localparam int ruche_dest_x_lsb_c  = ruche_dest_y_lsb_c + mesh_coord_pkg::y_cord_width_c;

endpackage

//--- design/mesh_link_fifo.sv
`timescale 1ns/100ps
/* link input FIFO
   two-entry buffer between an incoming link and the router core */
module mesh_link_fifo #(
  parameter int width_p = 8
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               v_i,
  input  logic [width_p-1:0] data_i,
  output logic               ready_and_o,
  output logic               v_o,
  output logic [width_p-1:0] data_o,
  input  logic               yumi_i
);

  logic [width_p-1:0] mem_r [2];
  logic               wr_ptr_r;
  logic               rd_ptr_r;
  logic [1:0]         count_r;
  logic               enq;

  // ready depends only on the fill level
  assign ready_and_o = (count_r != 2'd2);
  assign v_o         = (count_r != 2'd0);
  assign data_o      = mem_r[rd_ptr_r];
  assign enq         = v_i & ready_and_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      count_r  <= 2'd0;
    end else begin
      if (enq) wr_ptr_r <= ~wr_ptr_r;
      if (yumi_i) rd_ptr_r <= ~rd_ptr_r;
      count_r <= count_r + {1'b0, enq} - {1'b0, yumi_i};
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) mem_r[wr_ptr_r] <= data_i;
  end

  // the consumer only pops a head that is there
  a_no_pop_when_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    yumi_i |-> v_o);

endmodule

//--- design/mesh_route_decode.sv
`timescale 1ns/100ps
/* route decode
   dimension-ordered X then Y routing, ruche links for long horizontal hops */
module mesh_route_decode
  import mesh_coord_pkg::*;
#(
  parameter int ruche_factor_p = 3
) (
  input  logic [x_cord_width_c-1:0] dest_x_i,
  input  logic [y_cord_width_c-1:0] dest_y_i,
  input  logic [x_cord_width_c-1:0] my_x_i,
  input  logic [y_cord_width_c-1:0] my_y_i,
  output logic [dir_width_c-1:0]    dir_o
);

  logic [x_cord_width_c-1:0] dx_east;
  logic [x_cord_width_c-1:0] dx_west;

  assign dx_east = dest_x_i - my_x_i;  // only meaningful when heading east
  assign dx_west = my_x_i - dest_x_i;

  always_comb begin
    if (dest_x_i > my_x_i) begin
      // far enough away to jump a whole ruche span
      if (int'(dx_east) >= ruche_factor_p) begin
        dir_o = dir_re_c;
      end else begin
        dir_o = dir_e_c;
      end
    end else if (dest_x_i < my_x_i) begin
      if (int'(dx_west) >= ruche_factor_p) begin
        dir_o = dir_rw_c;
      end else begin
        dir_o = dir_w_c;
      end
    end else if (dest_y_i > my_y_i) begin
      dir_o = dir_s_c;  // y grows southward
    end else if (dest_y_i < my_y_i) begin
      dir_o = dir_n_c;
    end else begin
      dir_o = dir_p_c;  // arrived
    end
  end

endmodule

//--- design/mesh_output_arbiter.sv
`timescale 1ns/100ps
/* output arbiter
   round-robin grant over the seven inputs competing for one output */
module mesh_output_arbiter
  import mesh_coord_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic [num_dirs_c-1:0] req_i,
  input  logic                  ready_and_i,
  output logic [num_dirs_c-1:0] grant_o,
  output logic                  v_o
);

  logic [dir_width_c-1:0] ptr_r;      // highest priority input
  logic [dir_width_c-1:0] pick_idx;
  logic [num_dirs_c-1:0]  pick;
  logic [dir_width_c-1:0] win_idx;
  logic [dir_width_c-1:0] idx_r;
  logic [num_dirs_c-1:0]  grant_r;
  logic                   hold_r;     // winner stalled last cycle

  always_comb begin
    logic                   found;
    logic [dir_width_c-1:0] idx;
    found    = 1'b0;
    pick     = '0;
    pick_idx = ptr_r;
    idx      = ptr_r;
    for (int i = 0; i < num_dirs_c; i++) begin
      if (!found && req_i[idx]) begin
        found     = 1'b1;
        pick[idx] = 1'b1;
        pick_idx  = idx;
      end
      idx = (idx == dir_width_c'(num_dirs_c - 1)) ? '0 : idx + 1'b1;
    end
  end

  assign grant_o = hold_r ? grant_r : pick;
  assign win_idx = hold_r ? idx_r : pick_idx;
  assign v_o     = |grant_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_r  <= dir_p_c;
      hold_r <= 1'b0;
    end else begin
      hold_r <= v_o & ~ready_and_i;
      if (v_o && ready_and_i) begin
        ptr_r <= (win_idx == dir_width_c'(num_dirs_c - 1)) ? '0 : win_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    grant_r <= grant_o;
    idx_r   <= win_idx;
  end

  // a held grant must still point at a live request
  a_grant_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(grant_o) && ((grant_o & ~req_i) == '0));

endmodule

//--- design/mesh_node_router.sv
`timescale 1ns/100ps
/* mesh node router
   seven-port forward router, input FIFOs, route decode and per-output arbiters */
module mesh_node_router
  import mesh_coord_pkg::*;
  import mesh_packet_pkg::*;
#(
  parameter int                    ruche_factor_p = 3,
  parameter logic [num_dirs_c-1:0] stub_mask_p    = '0
) (
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  input  logic [num_dirs_c-1:0]                       link_v_i,
  input  logic [num_dirs_c-1:0][mesh_pkt_width_c-1:0] link_data_i,
  output logic [num_dirs_c-1:0]                       link_ready_and_o,
  output logic [num_dirs_c-1:0]                       link_v_o,
  output logic [num_dirs_c-1:0][mesh_pkt_width_c-1:0] link_data_o,
  input  logic [num_dirs_c-1:0]                       link_ready_and_i,
  input  logic [x_cord_width_c-1:0]                   global_x_i,
  input  logic [y_cord_width_c-1:0]                   global_y_i
);

  logic [num_dirs_c-1:0]                       fifo_v;
  logic [num_dirs_c-1:0][mesh_pkt_width_c-1:0] fifo_data;
  logic [num_dirs_c-1:0]                       fifo_ready;
  logic [num_dirs_c-1:0]                       fifo_yumi;
  logic [num_dirs_c-1:0][dir_width_c-1:0]      head_dir;
  logic [num_dirs_c-1:0][num_dirs_c-1:0]       req;    // [out][in]
  logic [num_dirs_c-1:0][num_dirs_c-1:0]       grant;  // [out][in]
  logic [num_dirs_c-1:0]                       arb_v;

  for (genvar i = 0; i < num_dirs_c; i++) begin : g_in
    mesh_link_fifo #(.width_p(mesh_pkt_width_c)) i_fifo (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .v_i        (link_v_i[i] & ~stub_mask_p[i]),  // dead port never enqueues
      .data_i     (link_data_i[i]),
      .ready_and_o(fifo_ready[i]),
      .v_o        (fifo_v[i]),
      .data_o     (fifo_data[i]),
      .yumi_i     (fifo_yumi[i])
    );

    assign link_ready_and_o[i] = stub_mask_p[i] | fifo_ready[i];

    mesh_route_decode #(.ruche_factor_p(ruche_factor_p)) i_decode (
      .dest_x_i(fifo_data[i][mesh_dest_x_lsb_c +: x_cord_width_c]),
      .dest_y_i(fifo_data[i][mesh_dest_y_lsb_c +: y_cord_width_c]),
      .my_x_i  (global_x_i),
      .my_y_i  (global_y_i),
      .dir_o   (head_dir[i])
    );

    // a packet headed for a stubbed side would sit in the FIFO forever
    a_no_route_to_stub: assert property (@(posedge clk_i) disable iff (reset_i)
      fifo_v[i] |-> !stub_mask_p[head_dir[i]]);
  end

  always_comb begin
    for (int o = 0; o < num_dirs_c; o++) begin
      for (int i = 0; i < num_dirs_c; i++) begin
        req[o][i] = fifo_v[i] & (head_dir[i] == dir_width_c'(o)) & ~stub_mask_p[o];
      end
    end
  end

  // pop a head once its granted output takes the beat
  always_comb begin
    for (int i = 0; i < num_dirs_c; i++) begin
      fifo_yumi[i] = 1'b0;
      for (int o = 0; o < num_dirs_c; o++) begin
        fifo_yumi[i] = fifo_yumi[i] | (grant[o][i] & link_ready_and_i[o]);
      end
    end
  end

  for (genvar o = 0; o < num_dirs_c; o++) begin : g_out
    mesh_output_arbiter i_arb (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .req_i      (req[o]),
      .ready_and_i(link_ready_and_i[o]),
      .grant_o    (grant[o]),
      .v_o        (arb_v[o])
    );

    always_comb begin
      link_data_o[o] = '0;  // also what a stub drives
      for (int i = 0; i < num_dirs_c; i++) begin
        if (grant[o][i]) link_data_o[o] = fifo_data[i];
      end
    end

    assign link_v_o[o] = arb_v[o] & ~stub_mask_p[o];
  end

endmodule

//--- design/hor_io_router.sv
`timescale 1ns/100ps
/* side-attached I/O router
   node one column outside the pod, with the accelerator on P and the far side tied off */
module hor_io_router
  import mesh_coord_pkg::*;
  import mesh_packet_pkg::*;
#(
  parameter int ruche_factor_p = 3,
  parameter bit tieoff_west_p  = 0,
  parameter bit tieoff_east_p  = 0,
  parameter bit tieoff_proc_p  = 0
) (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic [3:0]                          link_v_i,  // W, E, N, S
  input  logic [3:0][mesh_pkt_width_c-1:0]    link_data_i,
  output logic [3:0]                          link_ready_and_o,
  output logic [3:0]                          link_v_o,
  output logic [3:0][mesh_pkt_width_c-1:0]    link_data_o,
  input  logic [3:0]                          link_ready_and_i,
  input  logic                                proc_v_i,
  input  logic [mesh_pkt_width_c-1:0]         proc_data_i,
  output logic                                proc_ready_and_o,
  output logic                                proc_v_o,
  output logic [mesh_pkt_width_c-1:0]         proc_data_o,
  input  logic                                proc_ready_and_i,
  input  logic [1:0]                          ruche_v_i,  // RW, RE
  input  logic [1:0][ruche_pkt_width_c-1:0]   ruche_data_i,
  output logic [1:0]                          ruche_ready_and_o,
  output logic [1:0]                          ruche_v_o,
  output logic [1:0][ruche_pkt_width_c-1:0]   ruche_data_o,
  input  logic [1:0]                          ruche_ready_and_i,
  input  logic [x_cord_width_c-1:0]           global_x_i,
  input  logic [y_cord_width_c-1:0]           global_y_i
);

  // RE, RW, S, N, E, W, P
  localparam logic [num_dirs_c-1:0] stub_mask_lp = {
    tieoff_east_p, tieoff_west_p, 2'b00, tieoff_east_p, tieoff_west_p, tieoff_proc_p
  };

  logic [num_dirs_c-1:0]                       node_v_li;
  logic [num_dirs_c-1:0][mesh_pkt_width_c-1:0] node_data_li;
  logic [num_dirs_c-1:0]                       node_ready_and_lo;
  logic [num_dirs_c-1:0]                       node_v_lo;
  logic [num_dirs_c-1:0][mesh_pkt_width_c-1:0] node_data_lo;
  logic [num_dirs_c-1:0]                       node_ready_and_li;

  // ruche words travel without src_y, the row is implied by the link
  function automatic logic [mesh_pkt_width_c-1:0] inject_src_y(
    input logic [ruche_pkt_width_c-1:0] pkt,
    input logic [y_cord_width_c-1:0]    src_y);
    return {pkt[ruche_pkt_width_c-1:ruche_src_x_lsb_c], src_y, pkt[payload_width_c-1:0]};
  endfunction

  function automatic logic [ruche_pkt_width_c-1:0] strip_src_y(
    input logic [mesh_pkt_width_c-1:0] pkt);
    return {pkt[mesh_pkt_width_c-1:mesh_src_x_lsb_c], pkt[payload_width_c-1:0]};
  endfunction

  // tied-off sides become stubs in the node: v low, data zero, ready high
  assign node_v_li         = {ruche_v_i, link_v_i, proc_v_i};
  assign node_ready_and_li = {ruche_ready_and_i, link_ready_and_i, proc_ready_and_i};
  assign node_data_li      = {inject_src_y(ruche_data_i[1], global_y_i),
                              inject_src_y(ruche_data_i[0], global_y_i),
                              link_data_i, proc_data_i};

  assign {ruche_ready_and_o, link_ready_and_o, proc_ready_and_o} = node_ready_and_lo;
  assign {ruche_v_o, link_v_o, proc_v_o} = node_v_lo;
  assign proc_data_o     = node_data_lo[dir_p_c];
  assign link_data_o     = node_data_lo[dir_s_c:dir_w_c];
  assign ruche_data_o[0] = strip_src_y(node_data_lo[dir_rw_c]);
  assign ruche_data_o[1] = strip_src_y(node_data_lo[dir_re_c]);

  mesh_node_router #(
    .ruche_factor_p(ruche_factor_p),
    .stub_mask_p   (stub_mask_lp)
  ) i_node (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .link_v_i        (node_v_li),
    .link_data_i     (node_data_li),
    .link_ready_and_o(node_ready_and_lo),
    .link_v_o        (node_v_lo),
    .link_data_o     (node_data_lo),
    .link_ready_and_i(node_ready_and_li),
    .global_x_i      (global_x_i),
    .global_y_i      (global_y_i)
  );

  // the router sits on one side of the pod only
  a_one_side: assert property (@(posedge clk_i) !(tieoff_west_p && tieoff_east_p));

endmodule

//--- design/hor_io_top.sv
`timescale 1ns/100ps
/* I/O router top
   west-side I/O router with only its live E, N, S, P and RE links exposed */
module hor_io_top
  import mesh_coord_pkg::*;
  import mesh_packet_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic [2:0]                        link_v_i,  // E, N, S
  input  logic [2:0][mesh_pkt_width_c-1:0]  link_data_i,
  output logic [2:0]                        link_ready_and_o,
  output logic [2:0]                        link_v_o,
  output logic [2:0][mesh_pkt_width_c-1:0]  link_data_o,
  input  logic [2:0]                        link_ready_and_i,
  input  logic                              proc_v_i,
  input  logic [mesh_pkt_width_c-1:0]       proc_data_i,
  output logic                              proc_ready_and_o,
  output logic                              proc_v_o,
  output logic [mesh_pkt_width_c-1:0]       proc_data_o,
  input  logic                              proc_ready_and_i,
  input  logic                              ruche_v_i,  // RE only
  input  logic [ruche_pkt_width_c-1:0]      ruche_data_i,
  output logic                              ruche_ready_and_o,
  output logic                              ruche_v_o,
  output logic [ruche_pkt_width_c-1:0]      ruche_data_o,
  input  logic                              ruche_ready_and_i,
  input  logic [x_cord_width_c-1:0]         global_x_i,
  input  logic [y_cord_width_c-1:0]         global_y_i
);

  logic [3:0]                         rtr_link_ready_and_lo;
  logic [3:0]                         rtr_link_v_lo;
  logic [3:0][mesh_pkt_width_c-1:0]   rtr_link_data_lo;
  logic [1:0]                         rtr_ruche_ready_and_lo;
  logic [1:0]                         rtr_ruche_v_lo;
  logic [1:0][ruche_pkt_width_c-1:0]  rtr_ruche_data_lo;

  // west side faces away from the pod, slot 0 stays unconnected
  assign link_ready_and_o  = rtr_link_ready_and_lo[3:1];
  assign link_v_o          = rtr_link_v_lo[3:1];
  assign link_data_o       = rtr_link_data_lo[3:1];
  assign ruche_ready_and_o = rtr_ruche_ready_and_lo[1];
  assign ruche_v_o         = rtr_ruche_v_lo[1];
  assign ruche_data_o      = rtr_ruche_data_lo[1];

  hor_io_router #(
    .ruche_factor_p(3),
    .tieoff_west_p (1),
    .tieoff_east_p (0),
    .tieoff_proc_p (0)
  ) i_hor_io_router (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .link_v_i         ({link_v_i, 1'b0}),
    .link_data_i      ({link_data_i, {mesh_pkt_width_c{1'b0}}}),
    .link_ready_and_o (rtr_link_ready_and_lo),
    .link_v_o         (rtr_link_v_lo),
    .link_data_o      (rtr_link_data_lo),
    .link_ready_and_i ({link_ready_and_i, 1'b1}),
    .proc_v_i         (proc_v_i),
    .proc_data_i      (proc_data_i),
    .proc_ready_and_o (proc_ready_and_o),
    .proc_v_o         (proc_v_o),
    .proc_data_o      (proc_data_o),
    .proc_ready_and_i (proc_ready_and_i),
    .ruche_v_i        ({ruche_v_i, 1'b0}),
    .ruche_data_i     ({ruche_data_i, {ruche_pkt_width_c{1'b0}}}),
    .ruche_ready_and_o(rtr_ruche_ready_and_lo),
    .ruche_v_o        (rtr_ruche_v_lo),
    .ruche_data_o     (rtr_ruche_data_lo),
    .ruche_ready_and_i({ruche_ready_and_i, 1'b1}),
    .global_x_i       (global_x_i),
    .global_y_i       (global_y_i)
  );

endmodule

//--- test/hor_io_checks.svh
/* I/O router port checks
   every delivered beat is matched against the expected queue of its source */
`ifndef hor_io_checks_svh
`define hor_io_checks_svh

  for (genvar o = 0; o < num_outs_c; o++) begin : g_chk
    // nothing outstanding for that source means a made-up or duplicated beat
    a_beat_known: assert property (@(posedge clk_i) disable iff (reset_i)
      out_v[o] && out_rdy[o] |-> exp_avail[o])
      else begin
        proto_errs++;
        $display("%s: output %0d delivered a beat that was never sent, word %h",
                 test_name, o, $sampled(out_data[o]));
      end

    a_beat_value: assert property (@(posedge clk_i) disable iff (reset_i)
      out_v[o] && out_rdy[o] && exp_avail[o] |-> out_data[o] == exp_head[o])
      else begin
        value_errs++;
        $display("CHECK FAILED %s output %0d: expected %h, actual %h",
                 test_name, o, $sampled(exp_head[o]), $sampled(out_data[o]));
      end

    // stalled winner keeps v and data
    a_stall_stable: assert property (@(posedge clk_i) disable iff (reset_i)
      out_v[o] && !out_rdy[o] |=> out_v[o] && out_data[o] == $past(out_data[o]))
      else begin
        proto_errs++;
        $display("%s: output %0d dropped or changed a beat while stalled", test_name, o);
      end
  end

  a_reset_idle: assert property (@(posedge clk_i)
    reset_i |=> out_v == '0 && in_rdy == '1)
    else begin
      proto_errs++;
      $display("after reset an output is valid or an input is not ready");
    end

`endif

//--- test/tb_hor_io_top.sv
`timescale 1ns/100ps
/* testbench for the west-side I/O router top
   drives P, E and RE and keeps expected queues per output and source */
module tb_hor_io_top
  import mesh_coord_pkg::*;
  import mesh_packet_pkg::*;
();

  localparam int wait_limit_c = 200;
  localparam int q_depth_c    = 16;
  localparam int num_outs_c   = 5;
  localparam int out_p_c  = 0;
  localparam int out_e_c  = 1;
  localparam int out_n_c  = 2;
  localparam int out_s_c  = 3;
  localparam int out_re_c = 4;
  localparam int src_p_c  = 0;
  localparam int src_e_c  = 1;
  localparam int src_re_c = 2;
  localparam int sx_p_c   = 0;  // src_x each source puts in its packets
  localparam int sx_e_c   = 1;
  localparam int sx_re_c  = 3;
  localparam int my_x_c   = 0;
  localparam int my_y_c   = 2;
  localparam int ruche_c  = 3;

  logic                               clk_i;
  logic                               reset_i;
  logic [2:0]                         link_v_i;
  logic [2:0][mesh_pkt_width_c-1:0]   link_data_i;
  logic [2:0]                         link_ready_and_o;
  logic [2:0]                         link_v_o;
  logic [2:0][mesh_pkt_width_c-1:0]   link_data_o;
  logic [2:0]                         link_ready_and_i;
  logic                               proc_v_i;
  logic [mesh_pkt_width_c-1:0]        proc_data_i;
  logic                               proc_ready_and_o;
  logic                               proc_v_o;
  logic [mesh_pkt_width_c-1:0]        proc_data_o;
  logic                               proc_ready_and_i;
  logic                               ruche_v_i;
  logic [ruche_pkt_width_c-1:0]       ruche_data_i;
  logic                               ruche_ready_and_o;
  logic                               ruche_v_o;
  logic [ruche_pkt_width_c-1:0]       ruche_data_o;
  logic                               ruche_ready_and_i;
  logic [x_cord_width_c-1:0]          global_x_i;
  logic [y_cord_width_c-1:0]          global_y_i;

  logic [num_outs_c-1:0]       out_v;
  logic [num_outs_c-1:0]       out_rdy;
  logic [num_outs_c-1:0]       in_rdy;
  logic [mesh_pkt_width_c-1:0] out_data [num_outs_c];
  logic [x_cord_width_c-1:0]   out_sx [num_outs_c];
  logic [1:0]                  src_of [num_outs_c];
  logic [num_outs_c-1:0]       exp_avail;
  logic [mesh_pkt_width_c-1:0] exp_head [num_outs_c];
  logic [mesh_pkt_width_c-1:0] exp_mem [num_outs_c][4][q_depth_c];  // [out][src][slot]
  int unsigned                 wr_cnt [num_outs_c][4];
  int unsigned                 rd_cnt [num_outs_c][4];
  logic [31:0]                 lfsr_r;
  logic                        rand_rdy_en;
  int                          value_errs;
  int                          proto_errs;
  string                       test_name;

  hor_io_top i_hor_io_top (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .link_v_i         (link_v_i),
    .link_data_i      (link_data_i),
    .link_ready_and_o (link_ready_and_o),
    .link_v_o         (link_v_o),
    .link_data_o      (link_data_o),
    .link_ready_and_i (link_ready_and_i),
    .proc_v_i         (proc_v_i),
    .proc_data_i      (proc_data_i),
    .proc_ready_and_o (proc_ready_and_o),
    .proc_v_o         (proc_v_o),
    .proc_data_o      (proc_data_o),
    .proc_ready_and_i (proc_ready_and_i),
    .ruche_v_i        (ruche_v_i),
    .ruche_data_i     (ruche_data_i),
    .ruche_ready_and_o(ruche_ready_and_o),
    .ruche_v_o        (ruche_v_o),
    .ruche_data_o     (ruche_data_o),
    .ruche_ready_and_i(ruche_ready_and_i),
    .global_x_i       (global_x_i),
    .global_y_i       (global_y_i)
  );

  always #2 clk_i = ~clk_i;

  // output order P, E, N, S, RE
  assign out_v   = {ruche_v_o, link_v_o, proc_v_o};
  assign out_rdy = {ruche_ready_and_i, link_ready_and_i, proc_ready_and_i};
  assign in_rdy  = {ruche_ready_and_o, link_ready_and_o, proc_ready_and_o};
  assign out_data[out_p_c]  = proc_data_o;
  assign out_data[out_e_c]  = link_data_o[0];
  assign out_data[out_n_c]  = link_data_o[1];
  assign out_data[out_s_c]  = link_data_o[2];
  assign out_data[out_re_c] = mesh_pkt_width_c'(ruche_data_o);

  function automatic logic [1:0] src_from_sx(input logic [x_cord_width_c-1:0] sx);
    case (int'(sx))
      sx_p_c:  return 2'(src_p_c);
      sx_e_c:  return 2'(src_e_c);
      sx_re_c: return 2'(src_re_c);
      default: return 2'd3;  // unknown source, queue always empty
    endcase
  endfunction

  for (genvar o = 0; o < num_outs_c; o++) begin : g_exp
    assign out_sx[o] = (o == out_re_c) ? out_data[o][ruche_src_x_lsb_c +: x_cord_width_c]
                                       : out_data[o][mesh_src_x_lsb_c +: x_cord_width_c];
    assign src_of[o]    = src_from_sx(out_sx[o]);
    assign exp_avail[o] = rd_cnt[o][src_of[o]] != wr_cnt[o][src_of[o]];
    assign exp_head[o]  = exp_mem[o][src_of[o]][rd_cnt[o][src_of[o]] % q_depth_c];
  end

  `include "hor_io_checks.svh"

  // fibonacci LFSR, taps 32 22 2 1
  function automatic logic lfsr_bit();
    lfsr_r = {lfsr_r[30:0], lfsr_r[31] ^ lfsr_r[21] ^ lfsr_r[1] ^ lfsr_r[0]};
    return lfsr_r[0];
  endfunction

  function automatic logic [payload_width_c-1:0] rand_payload();
    logic [payload_width_c-1:0] r;
    r = '0;
    for (int i = 0; i < payload_width_c; i++) begin
      r = {r[payload_width_c-2:0], lfsr_bit()};
    end
    return r;
  endfunction

  function automatic logic [mesh_pkt_width_c-1:0] pack_mesh(
    input logic [x_cord_width_c-1:0] dx, input logic [y_cord_width_c-1:0] dy,
    input logic [x_cord_width_c-1:0] sx, input logic [y_cord_width_c-1:0] sy,
    input logic [payload_width_c-1:0] pl);
    return {dx, dy, sx, sy, pl};
  endfunction

  function automatic logic [ruche_pkt_width_c-1:0] pack_ruche(
    input logic [x_cord_width_c-1:0] dx, input logic [y_cord_width_c-1:0] dy,
    input logic [x_cord_width_c-1:0] sx, input logic [payload_width_c-1:0] pl);
    return {dx, dy, sx, pl};
  endfunction

  // X first, ruche once the hop reaches the ruche span, y grows southward
  function automatic int route_out(input logic [x_cord_width_c-1:0] dx,
                                   input logic [y_cord_width_c-1:0] dy);
    if (int'(dx) > my_x_c) begin
      return (int'(dx) - my_x_c >= ruche_c) ? out_re_c : out_e_c;
    end
    if (int'(dy) > my_y_c) return out_s_c;
    if (int'(dy) < my_y_c) return out_n_c;
    return out_p_c;
  endfunction

  task record(input int s, input logic [mesh_pkt_width_c-1:0] w);
    logic [x_cord_width_c-1:0]   dx;
    logic [y_cord_width_c-1:0]   dy;
    logic [x_cord_width_c-1:0]   sx;
    logic [mesh_pkt_width_c-1:0] e;
    int                          o;
    dx = w[mesh_dest_x_lsb_c +: x_cord_width_c];
    dy = w[mesh_dest_y_lsb_c +: y_cord_width_c];
    sx = w[mesh_src_x_lsb_c +: x_cord_width_c];
    o  = route_out(dx, dy);
    e  = w;
    if (o == out_re_c) begin
      e = mesh_pkt_width_c'(pack_ruche(dx, dy, sx, w[payload_width_c-1:0]));
    end
    exp_mem[o][s][wr_cnt[o][s] % q_depth_c] <= e;
    wr_cnt[o][s] <= wr_cnt[o][s] + 1;
  endtask

  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (proc_v_i && proc_ready_and_o) record(src_p_c, proc_data_i);
      if (link_v_i[0] && link_ready_and_o[0]) record(src_e_c, link_data_i[0]);
      if (ruche_v_i && ruche_ready_and_o) begin
        record(src_re_c, pack_mesh(ruche_data_i[ruche_dest_x_lsb_c +: x_cord_width_c],
                                   ruche_data_i[ruche_dest_y_lsb_c +: y_cord_width_c],
                                   ruche_data_i[ruche_src_x_lsb_c +: x_cord_width_c],
                                   global_y_i, ruche_data_i[payload_width_c-1:0]));
      end
    end
  end

  always @(posedge clk_i) begin
    for (int o = 0; o < num_outs_c; o++) begin
      if (!reset_i && out_v[o] && out_rdy[o] && exp_avail[o]) begin
        rd_cnt[o][src_of[o]] <= rd_cnt[o][src_of[o]] + 1;
      end
    end
  end

  always begin
    @(posedge clk_i);
    #1;
    proc_ready_and_i = rand_rdy_en ? lfsr_bit() : 1'b1;  // P back-pressure
  end

  task automatic tick();
    @(posedge clk_i);
    #1;
  endtask

  task automatic drive(input int s, input logic v, input logic [mesh_pkt_width_c-1:0] w);
    case (s)
      src_p_c: begin
        proc_v_i    = v;
        proc_data_i = w;
      end
      src_e_c: begin
        link_v_i[0]    = v;
        link_data_i[0] = w;
      end
      default: begin
        ruche_v_i    = v;
        ruche_data_i = w[ruche_pkt_width_c-1:0];
      end
    endcase
  endtask

  function automatic logic port_ready(input int s);
    case (s)
      src_p_c: return proc_ready_and_o;
      src_e_c: return link_ready_and_o[0];
      default: return ruche_ready_and_o;
    endcase
  endfunction

  task automatic send(input int s, input logic [mesh_pkt_width_c-1:0] w);
    int t;
    t = 0;
    drive(s, 1'b1, w);
    while (!port_ready(s) && t < wait_limit_c) begin
      tick();
      t++;
    end
    if (t == wait_limit_c) begin
      proto_errs++;
      $display("%s: input %0d never became ready", test_name, s);
    end
    tick();  // beat taken on this edge
    drive(s, 1'b0, '0);
  endtask

  function automatic logic drained();
    for (int o = 0; o < num_outs_c; o++) begin
      for (int s = 0; s < 4; s++) begin
        if (rd_cnt[o][s] != wr_cnt[o][s]) return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic wait_drain();
    int t;
    t = 0;
    while (!drained() && t < wait_limit_c) begin
      tick();
      t++;
    end
    if (!drained()) begin
      proto_errs++;
      $display("%s: sent beats never came out of the router", test_name);
    end
  endtask

  initial begin
    lfsr_r            = 32'h3ef99fa0;
    clk_i             = 1'b0;
    reset_i           = 1'b1;
    link_v_i          = '0;
    link_data_i       = '0;
    link_ready_and_i  = '1;
    proc_v_i          = 1'b0;
    proc_data_i       = '0;
    proc_ready_and_i  = 1'b1;
    ruche_v_i         = 1'b0;
    ruche_data_i      = '0;
    ruche_ready_and_i = 1'b1;
    global_x_i        = x_cord_width_c'(my_x_c);
    global_y_i        = y_cord_width_c'(my_y_c);
    rand_rdy_en       = 1'b0;
    value_errs        = 0;
    proto_errs        = 0;
    test_name         = "reset";
    for (int o = 0; o < num_outs_c; o++) begin
      for (int s = 0; s < 4; s++) begin
        wr_cnt[o][s] = 0;
        rd_cnt[o][s] = 0;
      end
    end
    repeat (8) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    tick();

    test_name = "e_to_p";
    send(src_e_c, pack_mesh(4'd0, 3'd2, 4'(sx_e_c), 3'd5, rand_payload()));
    wait_drain();

    test_name = "p_to_e";
    send(src_p_c, pack_mesh(4'd1, 3'd2, 4'(sx_p_c), 3'd2, rand_payload()));
    send(src_p_c, pack_mesh(4'd2, 3'd0, 4'(sx_p_c), 3'd2, rand_payload()));
    wait_drain();

    test_name = "p_to_re";
    send(src_p_c, pack_mesh(4'd3, 3'd2, 4'(sx_p_c), 3'd2, rand_payload()));
    send(src_p_c, pack_mesh(4'd7, 3'd6, 4'(sx_p_c), 3'd2, rand_payload()));
    wait_drain();

    test_name = "p_to_s_n";
    send(src_p_c, pack_mesh(4'd0, 3'd3, 4'(sx_p_c), 3'd2, rand_payload()));
    send(src_p_c, pack_mesh(4'd0, 3'd1, 4'(sx_p_c), 3'd2, rand_payload()));
    wait_drain();

    test_name = "re_to_p";
    send(src_re_c, mesh_pkt_width_c'(pack_ruche(4'd0, 3'd2, 4'(sx_re_c), rand_payload())));
    wait_drain();

    // E and RE compete for a stalling P output
    test_name = "p_backpressure";
    rand_rdy_en = 1'b1;
    fork
      repeat (12) send(src_e_c, pack_mesh(4'd0, 3'd2, 4'(sx_e_c), 3'd6, rand_payload()));
      repeat (12) begin
        send(src_re_c, mesh_pkt_width_c'(pack_ruche(4'd0, 3'd2, 4'(sx_re_c),
                                                    rand_payload())));
      end
    join
    rand_rdy_en = 1'b0;
    wait_drain();

    $display("errors: %0d value mismatches, %0d protocol failures", value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- src.f
design/mesh_coord_pkg.sv
design/mesh_packet_pkg.sv
design/mesh_link_fifo.sv
design/mesh_route_decode.sv
design/mesh_output_arbiter.sv
design/mesh_node_router.sv
design/hor_io_router.sv
design/hor_io_top.sv
+incdir+test
test/tb_hor_io_top.sv

//--- run.sh
#!/bin/sh
# build and run the I/O router testbench with Verilator from the project root
rm -f sim.log build.log
verilator --binary --assert -Wno-fatal -f src.f --top-module tb_hor_io_top \
  > build.log 2>&1 &&
  ./obj_dir/Vtb_hor_io_top > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Simulation finished: PASS$" sim.log && echo "run.sh: test passed" ||
  { echo "run.sh: test failed, see build.log and sim.log"; exit 1; }
